// File: gameCfgPkg.sv
package gameCfgPkg;

    typedef logic [9:0] scoreT;
    typedef logic [3:0] levelT;
    typedef logic [9:0] respawnT;

    localparam scoreT maxScore = 10'd999;

    // Levels 1 to 6 have their own score band, anything above is the top level
    localparam int    numRatedLevels = 6;
    localparam levelT maxLevel       = 4'd9;

    // Upper score bound, index 0 is level 1
    localparam scoreT levelLimits [numRatedLevels] = '{
        10'd10, 10'd15, 10'd30, 10'd55, 10'd75, 10'd99
    };

    // Enemy respawn period in unit ticks
    localparam respawnT respawnTable [numRatedLevels] = '{
        10'd70, 10'd40, 10'd25, 10'd15, 10'd10, 10'd5
    };
    localparam respawnT defaultRespawn = 10'd40; // Levels without a table entry

endpackage

// File: hudPkg.sv
package hudPkg;

    typedef logic [8:0]  pixelT;
    typedef logic [14:0] glyphAddrT;

    localparam int glyphW    = 20;
    localparam int glyphH    = 25;
    localparam int glyphArea = glyphW * glyphH; // ROM words per glyph

    localparam int glyphL = 10; // Digits occupy glyphs 0 to 9

    // Overlay origins, top left corner of each box
    localparam pixelT levelLX     = 9'd267;
    localparam pixelT levelLY     = 9'd26;
    localparam pixelT levelDigitX = 9'd287;
    localparam pixelT levelDigitY = 9'd24;
    localparam pixelT scoreX      = 9'd20;
    localparam pixelT scoreY      = 9'd24;

    localparam int scoreDigits = 3;

    function automatic logic inBox(pixelT x, pixelT y, pixelT ox, pixelT oy);
        return (x >= ox) && (x < ox + glyphW) && (y >= oy) && (y < oy + glyphH);
    endfunction

    // Row-major offset inside the box, then skip to the wanted glyph
    function automatic glyphAddrT glyphOffset(pixelT x, pixelT y, pixelT ox, pixelT oy,
                                              int unsigned idx);
        pixelT dx;
        pixelT dy;
        dx = x - ox;
        dy = y - oy;
        return glyphAddrT'(dy * glyphW + dx + idx * glyphArea);
    endfunction

endpackage

// File: scoreKeeper.sv
module scoreKeeper (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              killPulse,
    output gameCfgPkg::scoreT totalScore
);

    import gameCfgPkg::*;

    logic atMax;

    assign atMax = (totalScore >= maxScore);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            totalScore <= '0;
        end else if (killPulse && !atMax) begin
            totalScore <= totalScore + 1'b1;
        end
    end

    scoreBounded: assert property (
        @(posedge Clk) disable iff (!rstN)
        totalScore <= maxScore
    );

endmodule

// File: gameLevel.sv
module gameLevel (
    input  hudPkg::pixelT       PixelX,
    input  hudPkg::pixelT       PixelY,
    input  gameCfgPkg::scoreT   totalScore,
    output gameCfgPkg::levelT   gameLevel,
    output gameCfgPkg::respawnT enemyRespawnUnitTime,
    output logic                levelHit,
    output hudPkg::glyphAddrT   levelAddr
);

    import gameCfgPkg::*;
    import hudPkg::*;

    logic inL;
    logic inDigit;

    // Walk the bands from the top so the lowest matching level wins
    always_comb begin
        gameLevel = maxLevel;
        for (int i = numRatedLevels - 1; i >= 0; i--) begin
            if (totalScore <= levelLimits[i]) begin
                gameLevel = levelT'(i + 1);
            end
        end
    end

    always_comb begin
        enemyRespawnUnitTime = defaultRespawn;
        for (int i = 0; i < numRatedLevels; i++) begin
            if (gameLevel == levelT'(i + 1)) begin
                enemyRespawnUnitTime = respawnTable[i];
            end
        end
    end

    assign inL     = inBox(PixelX, PixelY, levelLX, levelLY);
    assign inDigit = inBox(PixelX, PixelY, levelDigitX, levelDigitY);

    always_comb begin
        levelHit  = 1'b0;
        levelAddr = '0;
        if (inL) begin
            levelHit  = 1'b1;
            levelAddr = glyphOffset(PixelX, PixelY, levelLX, levelLY, glyphL);
        end else if (inDigit) begin // Digit box starts where the L box ends
            levelHit  = 1'b1;
            levelAddr = glyphOffset(PixelX, PixelY, levelDigitX, levelDigitY, gameLevel);
        end
    end

endmodule

// File: scoreDisplay.sv
module scoreDisplay (
    input  hudPkg::pixelT     PixelX,
    input  hudPkg::pixelT     PixelY,
    input  gameCfgPkg::scoreT totalScore,
    output logic              scoreHit,
    output hudPkg::glyphAddrT scoreAddr
);

    import gameCfgPkg::*;
    import hudPkg::*;

    localparam int binW = $bits(scoreT);
    localparam int bcdW = 4 * scoreDigits;

    logic [bcdW+binW-1:0] dabble;
    logic [3:0]           digit [scoreDigits]; // Index 0 is the leftmost digit

    // Shift-and-add-3, BCD builds up above the binary part
    always_comb begin
        dabble = {{bcdW{1'b0}}, totalScore};
        for (int i = 0; i < binW; i++) begin
            for (int d = 0; d < scoreDigits; d++) begin
                if (dabble[binW+4*d +: 4] >= 4'd5) begin
                    dabble[binW+4*d +: 4] = dabble[binW+4*d +: 4] + 4'd3;
                end
            end
            dabble = dabble << 1;
        end
    end

    always_comb begin
        for (int k = 0; k < scoreDigits; k++) begin
            digit[k] = dabble[binW+4*(scoreDigits-1-k) +: 4];
        end
    end

    // Three boxes side by side, leading zeros stay visible
    always_comb begin
        scoreHit  = 1'b0;
        scoreAddr = '0;
        for (int k = 0; k < scoreDigits; k++) begin
            if (inBox(PixelX, PixelY, pixelT'(scoreX + k * glyphW), scoreY)) begin
                scoreHit  = 1'b1;
                scoreAddr = glyphOffset(PixelX, PixelY, pixelT'(scoreX + k * glyphW),
                                        scoreY, digit[k]);
            end
        end
    end

endmodule

// File: respawnTimer.sv
module respawnTimer (
    input  logic                Clk,
    input  logic                rstN,
    input  logic                unitTick,
    input  gameCfgPkg::respawnT enemyRespawnUnitTime,
    output logic                enemyRespawn
);

    import gameCfgPkg::*;

    respawnT tickCount;
    respawnT nextCount;
    logic    reached;

    assign nextCount = tickCount + 1'b1;
    assign reached   = (nextCount >= enemyRespawnUnitTime); // Also catches a shortened period

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            tickCount    <= '0;
            enemyRespawn <= 1'b0;
        end else begin
            enemyRespawn <= 1'b0;
            if (unitTick) begin
                if (reached) begin
                    tickCount    <= '0;
                    enemyRespawn <= 1'b1;
                end else begin
                    tickCount <= nextCount;
                end
            end
        end
    end

    // Shortest table period keeps pulses apart
    respawnSingle: assert property (
        @(posedge Clk) disable iff (!rstN)
        enemyRespawn |=> !enemyRespawn
    );

endmodule

// File: hudPixelMux.sv
module hudPixelMux (
    input  logic              Clk,
    input  logic              rstN,
    input  logic              levelHit,
    input  hudPkg::glyphAddrT levelAddr,
    input  logic              scoreHit,
    input  hudPkg::glyphAddrT scoreAddr,
    output logic              isObj,
    output hudPkg::glyphAddrT objAddress
);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            isObj      <= 1'b0;
            objAddress <= '0;
        end else begin
            isObj <= levelHit | scoreHit;
            if (levelHit) begin // Level overlay has priority
                objAddress <= levelAddr;
            end else if (scoreHit) begin
                objAddress <= scoreAddr;
            end else begin
                objAddress <= '0;
            end
        end
    end

    // Level and score overlays sit on opposite sides of the screen
    overlaysDisjoint: assert property (
        @(posedge Clk) disable iff (!rstN)
        !(levelHit && scoreHit)
    );

endmodule

// File: gameHud.sv
module gameHud (
    input  logic              Clk,
    input  logic              rstN,
    input  hudPkg::pixelT     PixelX,
    input  hudPkg::pixelT     PixelY,
    input  logic              killPulse,
    input  logic              unitTick,
    output logic              isObj,
    output hudPkg::glyphAddrT objAddress,
    output gameCfgPkg::levelT gameLevel,
    output logic              enemyRespawn
);

    import gameCfgPkg::*;
    import hudPkg::*;

    scoreT     totalScore;
    respawnT   enemyRespawnUnitTime;
    logic      levelHit;
    glyphAddrT levelAddr;
    logic      scoreHit;
    glyphAddrT scoreAddr;

    scoreKeeper uScore (
        .Clk        (Clk),
        .rstN       (rstN),
        .killPulse  (killPulse),
        .totalScore (totalScore)
    );

    gameLevel uLevel (
        .PixelX               (PixelX),
        .PixelY               (PixelY),
        .totalScore           (totalScore),
        .gameLevel            (gameLevel),
        .enemyRespawnUnitTime (enemyRespawnUnitTime),
        .levelHit             (levelHit),
        .levelAddr            (levelAddr)
    );

    scoreDisplay uScoreDisp (
        .PixelX     (PixelX),
        .PixelY     (PixelY),
        .totalScore (totalScore),
        .scoreHit   (scoreHit),
        .scoreAddr  (scoreAddr)
    );

    respawnTimer uRespawn (
        .Clk                  (Clk),
        .rstN                 (rstN),
        .unitTick             (unitTick),
        .enemyRespawnUnitTime (enemyRespawnUnitTime),
        .enemyRespawn         (enemyRespawn)
    );

    hudPixelMux uMux (
        .Clk        (Clk),
        .rstN       (rstN),
        .levelHit   (levelHit),
        .levelAddr  (levelAddr),
        .scoreHit   (scoreHit),
        .scoreAddr  (scoreAddr),
        .isObj      (isObj),
        .objAddress (objAddress)
    );

endmodule

// File: tbGameHud.sv
module tbGameHud;
    timeunit 1ns;
    timeprecision 1ps;

    import gameCfgPkg::*;
    import hudPkg::*;

    localparam int clkPeriod     = 4;
    localparam int resetCycles   = 4;
    localparam int slowCycles    = 4000; // Few kills, so each of levels 1 to 6 lasts a while
    localparam int fastCycles    = 1200;
    localparam int outsideCycles = 300;
    localparam int boxCycles     = 600;
    localparam int totalCycles   = resetCycles + 1 + slowCycles + fastCycles
                                   + outsideCycles + boxCycles;
    localparam real watchdogNs   = totalCycles * clkPeriod * 1.2;

    logic      Clk = 1'b0;
    logic      rstN;
    pixelT     PixelX;
    pixelT     PixelY;
    logic      killPulse;
    logic      unitTick;
    logic      isObj;
    glyphAddrT objAddress;
    levelT     gameLevel;
    logic      enemyRespawn;

    int        modelScore;
    int        modelCount; // Reference tick counter
    logic      expHit;
    glyphAddrT expAddr;
    logic      expRespawn;

    gameHud uut (
        .Clk          (Clk),
        .rstN         (rstN),
        .PixelX       (PixelX),
        .PixelY       (PixelY),
        .killPulse    (killPulse),
        .unitTick     (unitTick),
        .isObj        (isObj),
        .objAddress   (objAddress),
        .gameLevel    (gameLevel),
        .enemyRespawn (enemyRespawn)
    );

    always #(clkPeriod / 2) Clk = ~Clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s: expected %0b, actual %0b", name, expected, actual));
        end
    endtask

    task automatic checkLevel(input string name, input levelT expected, input levelT actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkScore(input string name, input scoreT expected, input scoreT actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic checkAddr(input string name, input glyphAddrT expected,
                             input glyphAddrT actual);
        if (actual !== expected) begin
            failRun($sformatf("[ERROR] %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    function automatic levelT levelOf(input int s);
        for (int i = 0; i < numRatedLevels; i++) begin
            if (s <= levelLimits[i]) begin
                return levelT'(i + 1);
            end
        end
        return maxLevel;
    endfunction

    function automatic int unitTimeOf(input levelT lv);
        if (lv >= 1 && lv <= numRatedLevels) begin
            return respawnTable[lv - 1];
        end
        return defaultRespawn;
    endfunction

    function automatic logic insideBox(input int x, input int y, input int ox, input int oy);
        return x >= ox && x < ox + glyphW && y >= oy && y < oy + glyphH;
    endfunction

    function automatic glyphAddrT boxAddr(input int x, input int y, input int ox, input int oy,
                                          input int glyph);
        return glyphAddrT'((y - oy) * glyphW + (x - ox) + glyph * glyphW * glyphH);
    endfunction

    // L box first, then level digit, then the three score digits
    function automatic void expectPixel(input int x, input int y, input int s,
                                        output logic hit, output glyphAddrT addr);
        int digits [3];
        digits[0] = s / 100;
        digits[1] = (s / 10) % 10;
        digits[2] = s % 10;
        hit  = 1'b1;
        addr = '0;
        if (insideBox(x, y, levelLX, levelLY)) begin
            addr = boxAddr(x, y, levelLX, levelLY, glyphL);
        end else if (insideBox(x, y, levelDigitX, levelDigitY)) begin
            addr = boxAddr(x, y, levelDigitX, levelDigitY, levelOf(s));
        end else begin
            hit = 1'b0;
            for (int k = 0; k < 3; k++) begin
                if (insideBox(x, y, scoreX + k * glyphW, scoreY)) begin
                    hit  = 1'b1;
                    addr = boxAddr(x, y, scoreX + k * glyphW, scoreY, digits[k]);
                end
            end
        end
    endfunction

    // Kinds: 0 L box, 1 level digit, 2 score digits, 3 clear of all boxes, 4 anywhere
    task automatic pickPixel(input int kind, output pixelT x, output pixelT y);
        int ox;
        int oy;
        ox = 0;
        oy = 0;
        case (kind)
            0: begin
                ox = levelLX;
                oy = levelLY;
            end
            1: begin
                ox = levelDigitX;
                oy = levelDigitY;
            end
            2: begin
                ox = scoreX + ($urandom % 3) * glyphW;
                oy = scoreY;
            end
            default: ;
        endcase
        if (kind <= 2) begin
            x = pixelT'(ox - 1 + $urandom % (glyphW + 2)); // One pixel of margin around the box
            y = pixelT'(oy - 1 + $urandom % (glyphH + 2));
        end else if (kind == 3) begin
            x = pixelT'(100 + $urandom % 150);
            y = pixelT'($urandom % 512);
        end else begin
            x = pixelT'($urandom % 512);
            y = pixelT'($urandom % 512);
        end
    endtask

    // Entered at a falling edge, leaves at the next one after checking
    task automatic runCycle(input string name, input int killRate, input int tickRate,
                            input int minKind, input int maxKind);
        pixelT x;
        pixelT y;
        int    next;
        pickPixel(minKind + $urandom % (maxKind - minKind + 1), x, y);
        PixelX    = x;
        PixelY    = y;
        killPulse = ($urandom % 1000) < killRate;
        unitTick  = ($urandom % 1000) < tickRate;

        expectPixel(x, y, modelScore, expHit, expAddr);
        expRespawn = 1'b0;
        if (unitTick) begin
            next = modelCount + 1;
            if (next >= unitTimeOf(levelOf(modelScore))) begin
                modelCount = 0;
                expRespawn = 1'b1;
            end else begin
                modelCount = next;
            end
        end
        if (killPulse && modelScore < maxScore) modelScore++;

        @(posedge Clk);
        @(negedge Clk);
        checkLevel({name, " gameLevel"}, levelOf(modelScore), gameLevel);
        checkScore({name, " totalScore"}, scoreT'(modelScore), uut.totalScore);
        checkBit({name, " isObj"}, expHit, isObj);
        checkAddr({name, " objAddress"}, expAddr, objAddress);
        checkBit({name, " enemyRespawn"}, expRespawn, enemyRespawn);
    endtask

    initial begin
        #(watchdogNs);
        failRun("Timeout: the tests did not finish within the time limit");
    end

    initial begin
        void'($urandom(32'h91bffc27));
        rstN       = 1'b0;
        killPulse  = 1'b0;
        unitTick   = 1'b0;
        PixelX     = '0;
        PixelY     = '0;
        modelScore = 0;
        modelCount = 0;

        repeat (resetCycles) @(negedge Clk);
        rstN = 1'b1;
        checkBit("reset isObj", 1'b0, isObj);
        checkAddr("reset objAddress", '0, objAddress);
        checkBit("reset enemyRespawn", 1'b0, enemyRespawn);
        checkLevel("reset gameLevel", 4'd1, gameLevel);

        for (int i = 0; i < slowCycles; i++) runCycle("slowClimb", 31, 700, 0, 4);
        for (int i = 0; i < fastCycles; i++) runCycle("fastClimb", 875, 700, 0, 4);
        checkScore("saturation", maxScore, uut.totalScore);
        checkLevel("saturation", maxLevel, gameLevel);
        for (int i = 0; i < outsideCycles; i++) runCycle("outsidePixels", 0, 700, 3, 3);
        for (int i = 0; i < boxCycles; i++) runCycle("boxPixels", 500, 700, 0, 2);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: sources.f
gameCfgPkg.sv
hudPkg.sv
scoreKeeper.sv
gameLevel.sv
scoreDisplay.sv
respawnTimer.sv
hudPixelMux.sv
gameHud.sv
tbGameHud.sv

// File: Bender.yml
package:
  name: gameHud

sources:
  - gameCfgPkg.sv
  - hudPkg.sv
  - scoreKeeper.sv
  - gameLevel.sv
  - scoreDisplay.sv
  - respawnTimer.sv
  - hudPixelMux.sv
  - gameHud.sv
  - target: test
    files:
      - tbGameHud.sv
